// File: source/core_cfg.svh
//////////////////////////////////////////////////
// core configuration
// widths, reset pc and fixed encodings of the core
//////////////////////////////////////////////////

`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define CORE_XLEN         32
`define CORE_REG_COUNT    32
`define CORE_REG_IDX_BITS 5

`define CORE_RESET_PC     32'h0000_0000
`define CORE_NOP          32'h0000_0013 // addi x0, x0, 0
`define CORE_ZERO_REG     5'd0

`endif

// File: source/core_pkg.sv
//////////////////////////////////////////////////
// core types
// opcodes, alu ops, error status and the packets
// passed between pipeline stages
//////////////////////////////////////////////////

`include "core_cfg.svh"

package core_pkg;

	typedef logic [`CORE_XLEN-1:0]         word_t;
	typedef logic [`CORE_REG_IDX_BITS-1:0] reg_idx_t;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP_REG    = 7'b0110011,
		OP_IMM    = 7'b0010011,
		OP_LUI    = 7'b0110111,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111,
		OP_SYSTEM = 7'b1110011
	} opcode_t;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0, // zero value doubles as the bubble op
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5
	} alu_op_t;

	typedef enum logic [1:0] {
		NO_ERROR      = 2'd0,
		ILLEGAL_INST  = 2'd1,
		HALTED_ON_WFI = 2'd2
	} error_status_t;

	////////////////////////////////////////////////// 
	// pipeline packets
	//////////////////////////////////////////////////

	typedef struct packed {
		word_t       pc;
		word_t       npc;
		logic [31:0] inst;
		logic        valid;
	} fetch_packet_t;

	typedef struct packed {
		word_t    pc;
		word_t    npc;
		word_t    rs1_value;
		word_t    rs2_value;
		word_t    imm;
		reg_idx_t rs1_idx;
		reg_idx_t rs2_idx;
		reg_idx_t dest_idx;
		alu_op_t  alu_op;
		logic     opb_is_imm;
		logic     opa_is_zero;     // lui
		logic     is_cond_branch;
		logic     branch_on_equal; // beq, else bne
		logic     is_jal;
		logic     writes_reg;
		logic     halt;
		logic     illegal;
		logic     valid;
	} decode_packet_t;

	typedef struct packed {
		word_t    npc;
		word_t    result;
		reg_idx_t dest_idx;
		logic     writes_reg;
		logic     halt;
		logic     illegal;
		logic     valid;
	} execute_packet_t;

endpackage

// File: source/fetch_stage.sv
//////////////////////////////////////////////////
// fetch stage
// pc register, instruction port and IF/ID register
//////////////////////////////////////////////////

`include "core_cfg.svh"

module fetch_stage (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   take_branch,
	input  core_pkg::word_t        target_pc,
	input  core_pkg::word_t        instr_data,
	output core_pkg::word_t        instr_addr,
	output core_pkg::fetch_packet_t if_id
);

	core_pkg::word_t pc;
	core_pkg::word_t seq_pc;

	assign seq_pc     = pc + core_pkg::word_t'(4);
	assign instr_addr = pc; // port answers in the same cycle

	always_ff @(posedge clock) begin
		if (!reset) begin
			pc <= `CORE_RESET_PC;
		end else if (take_branch) begin
			pc <= target_pc; // redirect from EX/MEM
		end else begin
			pc <= seq_pc;
		end
	end

	// IF/ID register
	always_ff @(posedge clock) begin
		if (!reset || take_branch) begin
			if_id <= '{pc: '0, npc: '0, inst: `CORE_NOP, valid: 1'b0};
		end else begin
			if_id <= '{pc: pc, npc: seq_pc, inst: instr_data, valid: 1'b1};
		end
	end

endmodule

// File: source/register_file.sv
//////////////////////////////////////////////////
// register file
// two reads, one write, x0 tied to zero
//////////////////////////////////////////////////

`include "core_cfg.svh"

module register_file (
	input  logic              clock,
	input  logic              reset,
	input  core_pkg::reg_idx_t rs1_idx,
	input  core_pkg::reg_idx_t rs2_idx,
	output core_pkg::word_t    rs1_value,
	output core_pkg::word_t    rs2_value,
	input  logic              wr_en,
	input  core_pkg::reg_idx_t wr_idx,
	input  core_pkg::word_t    wr_data
);

	core_pkg::word_t regs [`CORE_REG_COUNT];

	always_ff @(posedge clock) begin
		if (!reset) begin
			for (int i = 0; i < `CORE_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_idx != `CORE_ZERO_REG)) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// write-through so a reader three slots behind sees the new value
	always_comb begin
		if (rs1_idx == `CORE_ZERO_REG)                rs1_value = '0;
		else if (wr_en && (wr_idx == rs1_idx))        rs1_value = wr_data;
		else                                          rs1_value = regs[rs1_idx];

		if (rs2_idx == `CORE_ZERO_REG)                rs2_value = '0;
		else if (wr_en && (wr_idx == rs2_idx))        rs2_value = wr_data;
		else                                          rs2_value = regs[rs2_idx];
	end

endmodule

// File: source/decode_stage.sv
//////////////////////////////////////////////////
// decode stage
// decoder, immediates, register read and the
// ID/EX register
//////////////////////////////////////////////////

module decode_stage (
	input  logic                     clock,
	input  logic                     reset,
	input  core_pkg::fetch_packet_t  if_id,
	input  logic                     take_branch,
	input  logic                     wb_wr_en,
	input  core_pkg::reg_idx_t       wb_wr_idx,
	input  core_pkg::word_t          wb_wr_data,
	output core_pkg::decode_packet_t id_ex
);

	localparam logic [31:0] wfi_word = 32'h1050_0073;

	core_pkg::decode_packet_t id_packet;
	core_pkg::opcode_t        opcode;
	logic [2:0]               funct3;
	logic [6:0]               funct7;
	core_pkg::word_t          imm_i, imm_u, imm_b, imm_j;
	core_pkg::word_t          rs1_value, rs2_value;

	assign opcode = core_pkg::opcode_t'(if_id.inst[6:0]);
	assign funct3 = if_id.inst[14:12];
	assign funct7 = if_id.inst[31:25];

	assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
	assign imm_u = {if_id.inst[31:12], 12'b0};
	assign imm_b = {{19{if_id.inst[31]}}, if_id.inst[31], if_id.inst[7],
			if_id.inst[30:25], if_id.inst[11:8], 1'b0};
	assign imm_j = {{11{if_id.inst[31]}}, if_id.inst[31], if_id.inst[19:12],
			if_id.inst[20], if_id.inst[30:21], 1'b0};

	register_file register_file_inst (
		.clock     (clock),
		.reset     (reset),
		.rs1_idx   (if_id.inst[19:15]),
		.rs2_idx   (if_id.inst[24:20]),
		.rs1_value (rs1_value),
		.rs2_value (rs2_value),
		.wr_en     (wb_wr_en),
		.wr_idx    (wb_wr_idx),
		.wr_data   (wb_wr_data)
	);

	//////////////////////////////////////////////////
	// decoder
	//////////////////////////////////////////////////

	always_comb begin
		id_packet.pc              = if_id.pc;
		id_packet.npc             = if_id.npc;
		id_packet.rs1_value       = rs1_value;
		id_packet.rs2_value       = rs2_value;
		id_packet.rs1_idx         = if_id.inst[19:15];
		id_packet.rs2_idx         = if_id.inst[24:20];
		id_packet.dest_idx        = if_id.inst[11:7];
		id_packet.imm             = imm_i;
		id_packet.alu_op          = core_pkg::ALU_ADD;
		id_packet.opb_is_imm      = 1'b0;
		id_packet.opa_is_zero     = 1'b0;
		id_packet.is_cond_branch  = 1'b0;
		id_packet.branch_on_equal = 1'b0;
		id_packet.is_jal          = 1'b0;
		id_packet.writes_reg      = 1'b0;
		id_packet.halt            = 1'b0;
		id_packet.illegal         = 1'b0;
		id_packet.valid           = if_id.valid;

		case (opcode)
			core_pkg::OP_REG: begin
				id_packet.writes_reg = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: id_packet.alu_op = core_pkg::ALU_ADD;
					{7'b0100000, 3'b000}: id_packet.alu_op = core_pkg::ALU_SUB;
					{7'b0000000, 3'b111}: id_packet.alu_op = core_pkg::ALU_AND;
					{7'b0000000, 3'b110}: id_packet.alu_op = core_pkg::ALU_OR;
					{7'b0000000, 3'b100}: id_packet.alu_op = core_pkg::ALU_XOR;
					{7'b0000000, 3'b010}: id_packet.alu_op = core_pkg::ALU_SLT;
					default:              id_packet.illegal = 1'b1;
				endcase
			end
			core_pkg::OP_IMM: begin // addi only
				id_packet.opb_is_imm = 1'b1;
				id_packet.writes_reg = 1'b1;
				id_packet.illegal    = (funct3 != 3'b000);
			end
			core_pkg::OP_LUI: begin
				id_packet.imm         = imm_u;
				id_packet.opa_is_zero = 1'b1; // 0 + imm
				id_packet.opb_is_imm  = 1'b1;
				id_packet.writes_reg  = 1'b1;
			end
			core_pkg::OP_BRANCH: begin
				id_packet.imm             = imm_b;
				id_packet.is_cond_branch  = 1'b1;
				id_packet.branch_on_equal = (funct3 == 3'b000);
				id_packet.illegal         = (funct3[2:1] != 2'b00);
			end
			core_pkg::OP_JAL: begin
				id_packet.imm        = imm_j;
				id_packet.is_jal     = 1'b1;
				id_packet.writes_reg = 1'b1; // link value is npc
			end
			core_pkg::OP_SYSTEM: begin
				id_packet.halt    = (if_id.inst == wfi_word);
				id_packet.illegal = (if_id.inst != wfi_word);
			end
			default: id_packet.illegal = 1'b1;
		endcase

		// an illegal word must not write or redirect
		if (id_packet.illegal) begin
			id_packet.writes_reg     = 1'b0;
			id_packet.is_cond_branch = 1'b0;
		end
		id_packet.writes_reg = id_packet.writes_reg && if_id.valid;
	end

	// ID/EX register
	always_ff @(posedge clock) begin
		if (!reset || take_branch) begin
			id_ex <= '0; // bubble
		end else begin
			id_ex <= id_packet;
		end
	end

endmodule

// File: source/execute_stage.sv
//////////////////////////////////////////////////
// execute stage
// forwarding, alu, branch resolve and EX/MEM
//////////////////////////////////////////////////

`include "core_cfg.svh"

module execute_stage (
	input  logic                      clock,
	input  logic                      reset,
	input  core_pkg::decode_packet_t  id_ex,
	input  logic                      wb_wr_en,
	input  core_pkg::reg_idx_t        wb_wr_idx,
	input  core_pkg::word_t           wb_wr_data,
	output core_pkg::execute_packet_t ex_mem,
	output logic                      take_branch,
	output core_pkg::word_t           target_pc
);

	logic                      ex_hit_a, ex_hit_b;
	logic                      wb_hit_a, wb_hit_b;
	core_pkg::word_t           rs1_fwd, rs2_fwd;
	core_pkg::word_t           opa, opb;
	core_pkg::word_t           alu_result;
	core_pkg::word_t           branch_target;
	logic                      branch_taken;
	core_pkg::execute_packet_t ex_packet;

	//////////////////////////////////////////////////
	// operand forwarding, EX/MEM is younger than WB
	//////////////////////////////////////////////////

	assign ex_hit_a = ex_mem.writes_reg && (ex_mem.dest_idx != `CORE_ZERO_REG)
			&& (ex_mem.dest_idx == id_ex.rs1_idx);
	assign ex_hit_b = ex_mem.writes_reg && (ex_mem.dest_idx != `CORE_ZERO_REG)
			&& (ex_mem.dest_idx == id_ex.rs2_idx);
	assign wb_hit_a = wb_wr_en && (wb_wr_idx == id_ex.rs1_idx); // wr_en implies rd != 0
	assign wb_hit_b = wb_wr_en && (wb_wr_idx == id_ex.rs2_idx);

	assign rs1_fwd = ex_hit_a ? ex_mem.result : (wb_hit_a ? wb_wr_data : id_ex.rs1_value);
	assign rs2_fwd = ex_hit_b ? ex_mem.result : (wb_hit_b ? wb_wr_data : id_ex.rs2_value);

	assign opa = id_ex.opa_is_zero ? '0 : rs1_fwd;
	assign opb = id_ex.opb_is_imm ? id_ex.imm : rs2_fwd;

	always_comb begin
		case (id_ex.alu_op)
			core_pkg::ALU_SUB: alu_result = opa - opb;
			core_pkg::ALU_AND: alu_result = opa & opb;
			core_pkg::ALU_OR:  alu_result = opa | opb;
			core_pkg::ALU_XOR: alu_result = opa ^ opb;
			core_pkg::ALU_SLT: alu_result = core_pkg::word_t'($signed(opa) < $signed(opb));
			default:           alu_result = opa + opb;
		endcase
	end

	// beq/bne compare and jal, both relative to pc
	assign branch_target = id_ex.pc + id_ex.imm;
	assign branch_taken  = id_ex.valid && (id_ex.is_jal || (id_ex.is_cond_branch
			&& ((rs1_fwd == rs2_fwd) == id_ex.branch_on_equal)));

	always_comb begin
		ex_packet.npc        = id_ex.npc;
		ex_packet.result     = id_ex.is_jal ? id_ex.npc : alu_result; // link
		ex_packet.dest_idx   = id_ex.dest_idx;
		ex_packet.writes_reg = id_ex.writes_reg;
		ex_packet.halt       = id_ex.halt;
		ex_packet.illegal    = id_ex.illegal;
		ex_packet.valid      = id_ex.valid;
	end

	// EX/MEM register, redirect acts while the branch sits here
	always_ff @(posedge clock) begin
		if (!reset || take_branch) begin
			ex_mem      <= '0;
			take_branch <= 1'b0;
		end else begin
			ex_mem      <= ex_packet;
			take_branch <= branch_taken;
		end
	end

	always_ff @(posedge clock) begin
		target_pc <= branch_target; // only read with take_branch
	end

endmodule

// File: source/retire_stage.sv
//////////////////////////////////////////////////
// retire stage
// MEM/WB register, writeback and error status
//////////////////////////////////////////////////

`include "core_cfg.svh"

module retire_stage (
	input  logic                      clock,
	input  logic                      reset,
	input  core_pkg::execute_packet_t ex_mem,
	output logic                      wb_wr_en,
	output core_pkg::reg_idx_t        wb_wr_idx,
	output core_pkg::word_t           wb_wr_data,
	output logic                      commit_valid,
	output core_pkg::word_t           commit_npc,
	output core_pkg::error_status_t   error_status
);

	core_pkg::execute_packet_t mem_wb;

	always_ff @(posedge clock) begin
		if (!reset) begin
			mem_wb       <= '0;
			error_status <= core_pkg::NO_ERROR;
		end else begin
			mem_wb <= ex_mem;
			// first offender wins, held until reset
			if ((error_status == core_pkg::NO_ERROR) && ex_mem.valid) begin
				if (ex_mem.illegal)
					error_status <= core_pkg::ILLEGAL_INST;
				else if (ex_mem.halt)
					error_status <= core_pkg::HALTED_ON_WFI;
			end
		end
	end

	// status already shows the offender while it sits in MEM/WB
	assign commit_valid = mem_wb.valid && (error_status == core_pkg::NO_ERROR);
	assign commit_npc   = mem_wb.npc;

	assign wb_wr_en   = commit_valid && mem_wb.writes_reg
			&& (mem_wb.dest_idx != `CORE_ZERO_REG);
	assign wb_wr_idx  = mem_wb.dest_idx;
	assign wb_wr_data = mem_wb.result;

endmodule

// File: source/pipeline_core.sv
//////////////////////////////////////////////////
// pipeline core top
// five-stage in-order core, stages wired in order
//////////////////////////////////////////////////

module pipeline_core (
	input  logic                    clock,
	input  logic                    reset,
	input  core_pkg::word_t         instr_data,
	output core_pkg::word_t         instr_addr,
	output logic                    commit_valid,
	output logic                    commit_wr_en,
	output core_pkg::reg_idx_t      commit_wr_idx,
	output core_pkg::word_t         commit_wr_data,
	output core_pkg::word_t         commit_npc,
	output core_pkg::error_status_t error_status
);

	core_pkg::fetch_packet_t   if_id;
	core_pkg::decode_packet_t  id_ex;
	core_pkg::execute_packet_t ex_mem;
	logic                      take_branch;
	core_pkg::word_t           target_pc;

	fetch_stage fetch_stage_inst (
		.clock       (clock),
		.reset       (reset),
		.take_branch (take_branch),
		.target_pc   (target_pc),
		.instr_data  (instr_data),
		.instr_addr  (instr_addr),
		.if_id       (if_id)
	);

	// commit write signals also feed the register file and forwarding
	decode_stage decode_stage_inst (
		.clock       (clock),
		.reset       (reset),
		.if_id       (if_id),
		.take_branch (take_branch),
		.wb_wr_en    (commit_wr_en),
		.wb_wr_idx   (commit_wr_idx),
		.wb_wr_data  (commit_wr_data),
		.id_ex       (id_ex)
	);

	execute_stage execute_stage_inst (
		.clock       (clock),
		.reset       (reset),
		.id_ex       (id_ex),
		.wb_wr_en    (commit_wr_en),
		.wb_wr_idx   (commit_wr_idx),
		.wb_wr_data  (commit_wr_data),
		.ex_mem      (ex_mem),
		.take_branch (take_branch),
		.target_pc   (target_pc)
	);

	retire_stage retire_stage_inst (
		.clock        (clock),
		.reset        (reset),
		.ex_mem       (ex_mem),
		.wb_wr_en     (commit_wr_en),
		.wb_wr_idx    (commit_wr_idx),
		.wb_wr_data   (commit_wr_data),
		.commit_valid (commit_valid),
		.commit_npc   (commit_npc),
		.error_status (error_status)
	);

endmodule

// File: dv/pipeline_core_tb.sv
//////////////////////////////////////////////////
// pipeline core testbench
// directed programs from an instruction memory model,
// commits compared with a sequential isa model
//////////////////////////////////////////////////

`include "core_cfg.svh"

module pipeline_core_tb;

	localparam int          clk_period    = 8;
	localparam int          reset_cycles  = 10;
	localparam int          settle_cycles = 20;
	localparam int          mem_words     = 64;
	localparam logic [31:0] wfi_word      = 32'h1050_0073;
	localparam logic [6:0]  f7_base       = 7'b0000000;
	localparam logic [6:0]  f7_alt        = 7'b0100000; // sub
	localparam logic [2:0]  f3_add        = 3'b000;
	localparam logic [2:0]  f3_slt        = 3'b010;
	localparam logic [2:0]  f3_xor        = 3'b100;
	localparam logic [2:0]  f3_or         = 3'b110;
	localparam logic [2:0]  f3_and        = 3'b111;

	logic                    clock;
	logic                    reset;
	core_pkg::word_t         instr_data;
	core_pkg::word_t         instr_addr;
	logic                    commit_valid;
	logic                    commit_wr_en;
	core_pkg::reg_idx_t      commit_wr_idx;
	core_pkg::word_t         commit_wr_data;
	core_pkg::word_t         commit_npc;
	core_pkg::error_status_t error_status;

	core_pkg::word_t         imem [mem_words];
	core_pkg::word_t         prog_len = '0;
	int                      seed;
	int                      budget_cycles = 0;
	int                      cycle_count = 0;
	int                      error_count = 0;
	int                      test_count = 0;
	int                      test_errors;
	string                   current_test;
	logic                    recording = 1'b0;

	// commits seen on the DUT and those the isa model expects
	logic                    got_en [$];
	core_pkg::reg_idx_t      got_idx [$];
	core_pkg::word_t         got_data [$];
	core_pkg::word_t         got_npc [$];
	logic                    exp_en [$];
	core_pkg::reg_idx_t      exp_idx [$];
	core_pkg::word_t         exp_data [$];
	core_pkg::word_t         exp_npc [$];
	core_pkg::error_status_t exp_status;

	pipeline_core pipeline_core_inst (
		.clock          (clock),
		.reset          (reset),
		.instr_data     (instr_data),
		.instr_addr     (instr_addr),
		.commit_valid   (commit_valid),
		.commit_wr_en   (commit_wr_en),
		.commit_wr_idx  (commit_wr_idx),
		.commit_wr_data (commit_wr_data),
		.commit_npc     (commit_npc),
		.error_status   (error_status)
	);

	// same-cycle instruction port with nop past the program end
	assign instr_data = ((instr_addr >> 2) < prog_len) ? imem[instr_addr[7:2]] : `CORE_NOP;

	initial begin
		clock = 1'b0;
		forever #(clk_period / 2) clock = ~clock;
	end

	always @(negedge clock) begin
		if (recording && commit_valid) begin
			got_en.push_back(commit_wr_en);
			got_idx.push_back(commit_wr_idx);
			got_data.push_back(commit_wr_data);
			got_npc.push_back(commit_npc);
		end
	end

	// watchdog budget grows as each test starts
	initial begin
		while (cycle_count <= budget_cycles) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("watchdog expired after %0d cycles in %s", cycle_count, current_test);
		$display("*** TEST FAILED ***");
		$finish;
	end

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic check_word(input string what, input core_pkg::word_t expected,
			input core_pkg::word_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s %s expected %h actual %h", current_test, what,
					expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_idx(input string what, input core_pkg::reg_idx_t expected,
			input core_pkg::reg_idx_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s %s expected x%0d actual x%0d", current_test, what,
					expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_status(input string what, input core_pkg::error_status_t expected,
			input core_pkg::error_status_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s %s expected %s actual %s", current_test, what,
					expected.name(), actual.name());
			test_errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s %s expected %b actual %b", current_test, what,
					expected, actual);
			test_errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// instruction encoders
	//////////////////////////////////////////////////

	function automatic core_pkg::word_t r_type_word(input logic [6:0] funct7,
			input logic [2:0] funct3, input core_pkg::reg_idx_t rd,
			input core_pkg::reg_idx_t rs1, input core_pkg::reg_idx_t rs2);
		return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
	endfunction

	function automatic core_pkg::word_t addi_word(input core_pkg::reg_idx_t rd,
			input core_pkg::reg_idx_t rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic core_pkg::word_t lui_word(input core_pkg::reg_idx_t rd,
			input logic [19:0] imm);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic core_pkg::word_t branch_word(input logic [2:0] funct3,
			input core_pkg::reg_idx_t rs1, input core_pkg::reg_idx_t rs2,
			input logic [12:0] offset);
		return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11],
				7'b1100011};
	endfunction

	function automatic core_pkg::word_t jal_word(input core_pkg::reg_idx_t rd,
			input logic [20:0] offset);
		return {offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'b1101111};
	endfunction

	function automatic core_pkg::word_t random_word();
		logic [31:0] r;
		r = $random(seed);
		return r;
	endfunction

	//////////////////////////////////////////////////
	// program flow
	//////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clock);
		#1; // inputs change just after the edge
	endtask

	task automatic add_inst(input core_pkg::word_t word);
		imem[prog_len[5:0]] = word;
		prog_len = prog_len + 1;
	endtask

	task automatic start_test(input string name);
		budget_cycles += 1; // the cycle spent here
		next_cycle();
		reset        = 1'b0;
		recording    = 1'b0;
		current_test = name;
		test_errors  = 0;
		prog_len     = '0;
		got_en.delete();
		got_idx.delete();
		got_data.delete();
		got_npc.delete();
	endtask

	task automatic finish_test();
		$display("%s %s", current_test, (test_errors == 0) ? "ok" : "errors");
		error_count += test_errors;
		test_count++;
	endtask

	// sequential isa model that stops at wfi or an illegal word
	task automatic model_program();
		core_pkg::word_t    model_regs [32];
		core_pkg::word_t    pc;
		core_pkg::word_t    next_pc;
		core_pkg::word_t    inst;
		core_pkg::word_t    a;
		core_pkg::word_t    b;
		core_pkg::word_t    imm;
		core_pkg::word_t    res;
		core_pkg::reg_idx_t rd;
		logic               writes;
		int                 steps;
		exp_en.delete();
		exp_idx.delete();
		exp_data.delete();
		exp_npc.delete();
		exp_status = core_pkg::NO_ERROR;
		foreach (model_regs[i]) model_regs[i] = '0;
		pc    = `CORE_RESET_PC;
		steps = 0;
		while ((exp_status == core_pkg::NO_ERROR) && (steps < 4 * mem_words)) begin
			inst    = ((pc >> 2) < prog_len) ? imem[pc[7:2]] : `CORE_NOP;
			a       = model_regs[inst[19:15]];
			b       = model_regs[inst[24:20]];
			rd      = inst[11:7];
			imm     = {{20{inst[31]}}, inst[31:20]};
			next_pc = pc + 32'd4;
			res     = '0;
			writes  = 1'b0;
			case (inst[6:0])
				7'b0110011: begin
					writes = 1'b1;
					case ({inst[31:25], inst[14:12]})
						10'h000: res = a + b;
						10'h100: res = a - b;
						10'h007: res = a & b;
						10'h006: res = a | b;
						10'h004: res = a ^ b;
						10'h002: res = {31'b0, ($signed(a) < $signed(b))};
						default: exp_status = core_pkg::ILLEGAL_INST;
					endcase
				end
				7'b0010011: begin
					writes = 1'b1;
					res    = a + imm;
					if (inst[14:12] != 3'b000) exp_status = core_pkg::ILLEGAL_INST;
				end
				7'b0110111: begin
					writes = 1'b1;
					res    = {inst[31:12], 12'b0};
				end
				7'b1100011: begin
					imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
					if (inst[14:13] != 2'b00) exp_status = core_pkg::ILLEGAL_INST;
					else if ((a == b) != inst[12]) next_pc = pc + imm; // beq or bne
				end
				7'b1101111: begin
					imm     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
					writes  = 1'b1;
					res     = pc + 32'd4;
					next_pc = pc + imm;
				end
				7'b1110011: begin
					if (inst == wfi_word) exp_status = core_pkg::HALTED_ON_WFI;
					else exp_status = core_pkg::ILLEGAL_INST;
				end
				default: exp_status = core_pkg::ILLEGAL_INST;
			endcase
			if (exp_status == core_pkg::NO_ERROR) begin
				exp_en.push_back(writes && (rd != `CORE_ZERO_REG));
				exp_idx.push_back(rd);
				exp_data.push_back(res);
				exp_npc.push_back(pc + 32'd4);
				if (writes && (rd != `CORE_ZERO_REG)) model_regs[rd] = res;
				pc = next_pc;
			end
			steps++;
		end
	endtask

	task automatic compare_commits();
		if (got_en.size() != exp_en.size()) begin
			$display("%s saw %0d commits where %0d were expected", current_test,
					got_en.size(), exp_en.size());
			test_errors++;
		end
		for (int i = 0; (i < exp_en.size()) && (i < got_en.size()); i++) begin
			check_word($sformatf("commit %0d npc", i), exp_npc[i], got_npc[i]);
			check_bit($sformatf("commit %0d wr_en", i), exp_en[i], got_en[i]);
			if (exp_en[i]) begin
				check_idx($sformatf("commit %0d wr_idx", i), exp_idx[i], got_idx[i]);
				check_word($sformatf("commit %0d wr_data", i), exp_data[i], got_data[i]);
			end
		end
	endtask

	// reset and run until the status leaves NO_ERROR before comparing
	task automatic run_program();
		int limit;
		int waited;
		model_program();
		limit          = int'(prog_len) + settle_cycles;
		budget_cycles += reset_cycles + limit + 6;
		repeat (reset_cycles) next_cycle();
		reset     = 1'b1;
		recording = 1'b1;
		waited    = 0;
		while ((error_status == core_pkg::NO_ERROR) && (waited < limit)) begin
			@(negedge clock);
			waited++;
		end
		if (error_status == core_pkg::NO_ERROR) begin
			$display("%s never halted or flagged an error within %0d cycles", current_test,
					limit);
			test_errors++;
		end
		repeat (4) @(negedge clock); // nothing may commit after the offender
		recording = 1'b0;
		compare_commits();
		check_status("error_status", exp_status, error_status);
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic reset_behavior();
		start_test("reset");
		budget_cycles += reset_cycles + 8;
		for (int i = 0; i < reset_cycles; i++) begin
			next_cycle();
			check_word("instr_addr in reset", `CORE_RESET_PC, instr_addr);
			check_bit("commit_valid in reset", 1'b0, commit_valid);
			check_bit("commit_wr_en in reset", 1'b0, commit_wr_en);
			check_status("error_status in reset", core_pkg::NO_ERROR, error_status);
		end
		reset = 1'b1;
		for (int i = 0; i < 3; i++) begin
			next_cycle();
			check_word("instr_addr after release", `CORE_RESET_PC + 32'(4 * (i + 1)),
					instr_addr);
			check_bit("commit_valid after release", 1'b0, commit_valid);
			check_bit("commit_wr_en after release", 1'b0, commit_wr_en);
			check_status("error_status after release", core_pkg::NO_ERROR, error_status);
		end
		next_cycle();
		check_bit("first commit", 1'b1, commit_valid); // nop writes nothing
		check_bit("first commit wr_en", 1'b0, commit_wr_en);
		finish_test();
	endtask

	task automatic independent_alu_ops();
		core_pkg::word_t r1;
		core_pkg::word_t r2;
		core_pkg::word_t r3;
		core_pkg::word_t r4;
		start_test("alu_ops");
		r1 = random_word();
		r2 = random_word();
		r3 = random_word();
		r4 = random_word();
		add_inst(addi_word(5'd1, 5'd0, r1[11:0]));
		add_inst(addi_word(5'd2, 5'd0, r2[11:0]));
		add_inst(lui_word(5'd3, r3[19:0]));
		add_inst(addi_word(5'd4, 5'd0, r4[11:0]));
		add_inst(r_type_word(f7_base, f3_add, 5'd5, 5'd1, 5'd2));
		add_inst(r_type_word(f7_alt, f3_add, 5'd6, 5'd1, 5'd2));
		add_inst(r_type_word(f7_base, f3_and, 5'd7, 5'd3, 5'd4));
		add_inst(r_type_word(f7_base, f3_or, 5'd8, 5'd3, 5'd4));
		add_inst(r_type_word(f7_base, f3_xor, 5'd9, 5'd1, 5'd4));
		add_inst(r_type_word(f7_base, f3_slt, 5'd10, 5'd1, 5'd2));
		add_inst(r_type_word(f7_base, f3_slt, 5'd11, 5'd2, 5'd1));
		add_inst(wfi_word);
		run_program();
		finish_test();
	endtask

	// distances of one, two and three instructions
	task automatic forwarding_chain();
		core_pkg::word_t r1;
		core_pkg::word_t r2;
		start_test("forwarding");
		r1 = random_word();
		r2 = random_word();
		add_inst(addi_word(5'd1, 5'd0, r1[11:0]));
		add_inst(addi_word(5'd2, 5'd1, r2[11:0]));
		add_inst(r_type_word(f7_base, f3_add, 5'd3, 5'd2, 5'd1));
		add_inst(r_type_word(f7_alt, f3_add, 5'd4, 5'd1, 5'd3));
		add_inst(r_type_word(f7_base, f3_xor, 5'd5, 5'd3, 5'd2));
		add_inst(r_type_word(f7_base, f3_or, 5'd6, 5'd4, 5'd5));
		add_inst(r_type_word(f7_base, f3_slt, 5'd7, 5'd6, 5'd4));
		add_inst(r_type_word(f7_base, f3_and, 5'd8, 5'd5, 5'd6));
		add_inst(addi_word(5'd8, 5'd8, r2[23:12]));
		add_inst(wfi_word);
		run_program();
		finish_test();
	endtask

	task automatic control_flow();
		start_test("control_flow");
		add_inst(addi_word(5'd1, 5'd0, 12'd5));
		add_inst(addi_word(5'd2, 5'd0, 12'd5));
		add_inst(branch_word(3'b000, 5'd1, 5'd2, 13'd16)); // taken beq to word 6
		add_inst(32'hffff_ffff);                            // shadow word never executes
		add_inst(addi_word(5'd3, 5'd0, 12'd2));
		add_inst(addi_word(5'd3, 5'd0, 12'd3));
		add_inst(jal_word(5'd4, 21'd16));                   // to word 10
		add_inst(addi_word(5'd4, 5'd0, 12'd1));
		add_inst(addi_word(5'd5, 5'd0, 12'd2));
		add_inst(addi_word(5'd5, 5'd0, 12'd3));
		add_inst(branch_word(3'b001, 5'd1, 5'd2, 13'd16)); // bne falls through
		add_inst(addi_word(5'd6, 5'd4, 12'd1));            // reads the link value
		add_inst(wfi_word);
		run_program();
		finish_test();
	endtask

	task automatic zero_register();
		core_pkg::word_t r1;
		start_test("zero_register");
		r1 = random_word();
		add_inst(addi_word(5'd0, 5'd0, 12'd123));
		add_inst(lui_word(5'd0, r1[19:0]));
		add_inst(r_type_word(f7_base, f3_add, 5'd1, 5'd0, 5'd0));
		add_inst(addi_word(5'd2, 5'd0, 12'd7));
		add_inst(r_type_word(f7_base, f3_add, 5'd0, 5'd2, 5'd2));
		add_inst(r_type_word(f7_base, f3_add, 5'd3, 5'd0, 5'd2));
		add_inst(wfi_word);
		run_program();
		finish_test();
	endtask

	task automatic illegal_instruction();
		start_test("illegal_inst");
		add_inst(addi_word(5'd1, 5'd0, 12'd1));
		add_inst(addi_word(5'd2, 5'd0, 12'd2));
		add_inst(r_type_word(7'b0000001, f3_add, 5'd3, 5'd1, 5'd2)); // mul
		add_inst(addi_word(5'd4, 5'd0, 12'd4));
		add_inst(addi_word(5'd5, 5'd0, 12'd5));
		add_inst(wfi_word);
		run_program();
		finish_test();
	endtask

	task automatic wfi_halt();
		start_test("wfi_halt");
		add_inst(addi_word(5'd1, 5'd0, 12'd9));
		add_inst(wfi_word);
		add_inst(addi_word(5'd2, 5'd0, 12'd3));
		add_inst(addi_word(5'd3, 5'd0, 12'd4));
		run_program();
		finish_test();
	endtask

	initial begin
		reset = 1'b0;
		seed  = 32'h7e9d;
		reset_behavior();
		independent_alu_ops();
		forwarding_chain();
		control_flow();
		zero_register();
		illegal_instruction();
		wfi_halt();
		$display("tests run %0d, failed checks %0d", test_count, error_count);
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+source
source/core_pkg.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/retire_stage.sv
source/pipeline_core.sv
dv/pipeline_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the core testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f sources.f --top-module pipeline_core_tb -o pipeline_core_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/pipeline_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -F -q "*** TEST FAILED ***" "$LOG"; then
	exit 1
fi
exit 0
